/* tb.f */
design/noc_pkg.sv
design/filereg_pkg.sv
design/lbdr_default_gen.sv
design/reg_array.sv
design/request_ctrl.sv
design/read_return.sv
design/filereg_top.sv
tb/tb_filereg.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_filereg
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_filereg.sv */
// register bank testbench
`timescale 1ns/1ps

module tb_filereg
  import noc_pkg::*;
  import filereg_pkg::*;
;

  localparam int     NUM_VNS    = 2;
  localparam int     NUM_ROWS   = 21;
  localparam int     NUM_RAND   = 200;
  localparam int     WATCHDOG   = (NUM_ROWS + NUM_RAND) * 20;
  // ids grow east and north from node 0 so west and south face the edge
  // xy routing 0x0f0 with cn and ce set
  localparam entry_t DEF_ENTRY  = 16'h00FC;

  // one cycle of stimulus with the expected handshake and read data
  typedef struct packed {
    logic      valid;
    cmd_e      cmd;
    entry_id_t id;
    entry_t    payload;
    logic      rsp_rdy;
    logic      exp_ready;
    entry_t    exp_data;
  } row_t;

  logic               clk_i;
  logic               rst_i;
  logic               req_valid_i;
  req_t               req_i;
  logic               req_ready_o;
  logic               rsp_valid_o;
  rsp_t               rsp_o;
  logic               rsp_ready_i;
  lbdr_t [NUM_VNS-1:0] lbdr_bits_o;

  row_t   rows [NUM_ROWS];
  entry_t model [DEPTH];
  rsp_t   exp_q [$];
  integer seed = 32'h778608c2;
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     test_cnt = 0;
  int     fail_cnt = 0;

  filereg_top #(
    .NodeId    (0),
    .NodesX    (4),
    .NodesY    (4),
    .XIncrease (EAST),
    .YIncrease (NORTH),
    .NumVns    (NUM_VNS)
  ) DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i),
    .lbdr_bits_o (lbdr_bits_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // checking helpers
  // ----------------------------------------------------------

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // bus image of the low model entries with vn 0 in the low bits
  function automatic logic [31:0] lbdr_expect();
    logic [31:0] bus;
    bus = '0;
    for (int v = 0; v < NUM_VNS; v++) begin
      bus[v*LBDR_W +: LBDR_W] = model[v][LBDR_W-1:0];
    end
    return bus;
  endfunction

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // drive on the falling edge, judge the transfer at the rising edge
  task automatic apply_row(input row_t r, output logic accepted);
    rsp_t exp_rsp;
    @(negedge clk_i);
    req_valid_i = r.valid;
    req_i       = '{cmd: r.cmd, entry_id: r.id, payload: r.payload};
    rsp_ready_i = r.rsp_rdy;
    @(posedge clk_i);
    check(32'(req_ready_o), 32'(r.exp_ready), "req_ready_o");
    // a response is pending exactly while a read sits unanswered
    check(32'(rsp_valid_o), 32'(exp_q.size() != 0), "rsp_valid_o");
    check(32'(lbdr_bits_o), lbdr_expect(), "lbdr_bits_o");
    if (rsp_valid_o && rsp_ready_i && (exp_q.size() != 0)) begin
      exp_rsp = exp_q.pop_front();
      check(32'(rsp_o), 32'(exp_rsp), "rsp_o");
    end
    accepted = r.valid && req_ready_o;
    if (accepted && (r.cmd == CMD_WRITE)) begin
      model[r.id] = r.payload;
    end
    if (accepted && (r.cmd == CMD_READ)) begin
      exp_q.push_back(rsp_t'{src_id: r.payload[SRC_ID_W-1:0], data: r.exp_data});
    end
  endtask

  task automatic run_rows(input int first, input int last, input string name);
    logic accepted;
    int   errs_before;
    errs_before = err_cnt;
    for (int i = first; i <= last; i++) begin
      apply_row(rows[i], accepted);
    end
    report_test(name, errs_before);
  endtask

  // random offers where a stalled request is held until it transfers
  task automatic run_random();
    row_t        r;
    logic [31:0] rnd;
    logic        accepted;
    logic        pending;
    int          done_ops;
    int          errs_before;
    errs_before = err_cnt;
    done_ops    = 0;
    pending     = 1'b0;
    r           = '0;
    while (done_ops < NUM_RAND) begin
      rnd = $random(seed);
      if (!pending) begin
        r.valid   = (rnd[5:4] != 2'b00);
        r.cmd     = rnd[0] ? CMD_READ : CMD_WRITE;
        r.id      = rnd[3:1];
        r.payload = entry_t'($random(seed));
      end
      r.rsp_rdy   = rnd[6];
      r.exp_ready = !(r.valid && (r.cmd == CMD_READ) && (exp_q.size() != 0) && !r.rsp_rdy);
      r.exp_data  = model[r.id];
      apply_row(r, accepted);
      pending = r.valid && !accepted;
      if (accepted) begin
        done_ops++;
      end
    end
    // drain whatever is still held
    apply_row(row_t'{1'b0, CMD_WRITE, 3'd0, 16'h0000, 1'b1, 1'b1, 16'h0000}, accepted);
    check(32'(exp_q.size()), 32'd0, "responses left over");
    report_test("random traffic", errs_before);
  endtask

  // ----------------------------------------------------------
  // stimulus table
  // ----------------------------------------------------------

  task automatic fill_table();
    // every entry read after reset back to back with the response side open
    for (int i = 0; i < DEPTH; i++) begin
      rows[i] = '{1'b1, CMD_READ, entry_id_t'(i), 16'(i + 1), 1'b1, 1'b1,
                  (i < NUM_VNS) ? DEF_ENTRY : 16'h0000};
    end
    // write then read back with source id a
    rows[8]  = '{1'b1, CMD_WRITE, 3'd5, 16'h1234, 1'b1, 1'b1, 16'h0000};
    rows[9]  = '{1'b1, CMD_READ,  3'd5, 16'h000A, 1'b1, 1'b1, 16'h1234};
    rows[10] = '{1'b0, CMD_WRITE, 3'd0, 16'h0000, 1'b1, 1'b1, 16'h0000};
    // vn entries reach the bus, entry 6 does not
    rows[11] = '{1'b1, CMD_WRITE, 3'd0, 16'hA5A5, 1'b1, 1'b1, 16'h0000};
    rows[12] = '{1'b1, CMD_WRITE, 3'd1, 16'hF123, 1'b1, 1'b1, 16'h0000};
    rows[13] = '{1'b1, CMD_WRITE, 3'd6, 16'h0777, 1'b1, 1'b1, 16'h0000};
    rows[14] = '{1'b1, CMD_READ,  3'd0, 16'h0002, 1'b1, 1'b1, 16'hA5A5};
    rows[15] = '{1'b0, CMD_WRITE, 3'd0, 16'h0000, 1'b1, 1'b1, 16'h0000};
    // held response keeps the old value, the write still goes in
    rows[16] = '{1'b1, CMD_READ,  3'd3, 16'h0003, 1'b0, 1'b1, 16'h0000};
    rows[17] = '{1'b1, CMD_WRITE, 3'd3, 16'hBEEF, 1'b0, 1'b1, 16'h0000};
    rows[18] = '{1'b1, CMD_READ,  3'd3, 16'h0007, 1'b0, 1'b0, 16'hBEEF};
    rows[19] = '{1'b1, CMD_READ,  3'd3, 16'h0007, 1'b1, 1'b1, 16'hBEEF};
    rows[20] = '{1'b0, CMD_WRITE, 3'd0, 16'h0000, 1'b1, 1'b1, 16'h0000};
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      model[i] = (i < NUM_VNS) ? DEF_ENTRY : 16'h0000;
    end
    fill_table();
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    run_rows(0, 7, "reset defaults");
    run_rows(8, 10, "write then read");
    run_rows(11, 15, "lbdr bus update");
    run_rows(16, 20, "back-pressure");
    run_random();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // bound on the whole run scaled by table rows and random ops
  initial begin
    repeat (WATCHDOG) @(posedge clk_i);
    $display("watchdog expired, the tests did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* design/filereg_top.sv */
// router configuration register bank
`timescale 1ns/1ps

module filereg_top
  import noc_pkg::*;
  import filereg_pkg::*;
#(
  parameter int unsigned NodeId    = 0,
  parameter int unsigned NodesX    = 4,
  parameter int unsigned NodesY    = 4,
  parameter dir_e        XIncrease = EAST,
  parameter dir_e        YIncrease = NORTH,
  parameter int          NumVns    = 2
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // request stream
  input  logic               req_valid_i,
  input  req_t               req_i,
  output logic               req_ready_o,
  // response stream
  output logic               rsp_valid_o,
  output rsp_t               rsp_o,
  input  logic               rsp_ready_i,
  // routing bits towards the router
  output lbdr_t [NumVns-1:0] lbdr_bits_o
);

  lbdr_t     def_entry;
  logic      wr_en;
  entry_id_t wr_id;
  entry_t    wr_data;
  entry_id_t rd_id;
  entry_t    rd_data;
  logic      rd_take;
  node_id_t  rd_src;
  logic      slot_free;

  // ----------------------------------------------------------
  // reset defaults
  // ----------------------------------------------------------

  lbdr_default_gen #(
    .NodeId    (NodeId),
    .NodesX    (NodesX),
    .NodesY    (NodesY),
    .XIncrease (XIncrease),
    .YIncrease (YIncrease)
  ) u_default (
    .def_entry_o (def_entry)
  );

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------

  reg_array #(
    .NumVns (NumVns)
  ) u_array (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .def_entry_i (def_entry),
    .wr_en_i     (wr_en),
    .wr_id_i     (wr_id),
    .wr_data_i   (wr_data),
    .rd_id_i     (rd_id),
    .rd_data_o   (rd_data),
    .lbdr_bits_o (lbdr_bits_o)
  );

  // ----------------------------------------------------------
  // request side and response side
  // ----------------------------------------------------------

  request_ctrl u_req (
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .slot_free_i (slot_free),
    .wr_en_o     (wr_en),
    .wr_id_o     (wr_id),
    .wr_data_o   (wr_data),
    .rd_id_o     (rd_id),
    .rd_take_o   (rd_take),
    .rd_src_o    (rd_src)
  );

  read_return u_rsp (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_take_i   (rd_take),
    .rd_src_i    (rd_src),
    .rd_data_i   (rd_data),
    .rsp_ready_i (rsp_ready_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .slot_free_o (slot_free)
  );

endmodule

/* design/read_return.sv */
// read response register
`timescale 1ns/1ps

module read_return
  import noc_pkg::*;
  import filereg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  // read accepted this cycle
  input  logic     rd_take_i,
  input  node_id_t rd_src_i,
  input  entry_t   rd_data_i,
  // response stream
  input  logic     rsp_ready_i,
  output logic     rsp_valid_o,
  output rsp_t     rsp_o,
  // no response held, or the held one leaves now
  output logic     slot_free_o
);

  typedef enum logic {
    EMPTY = 1'b0,
    FULL  = 1'b1
  } state_e;

  state_e state_q;
  state_e state_d;
  rsp_t   rsp_q;

  // ----------------------------------------------------------
  // slot state
  // ----------------------------------------------------------

  assign slot_free_o = (state_q == EMPTY) || rsp_ready_i;

  always_comb begin
    state_d = state_q;
    if (rd_take_i) begin
      // new read replaces a draining response, or fills an empty slot
      state_d = FULL;
    end else if ((state_q == FULL) && rsp_ready_i) begin
      state_d = EMPTY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // captured response
  // ----------------------------------------------------------

  // value frozen at acceptance, later writes do not reach it
  always_ff @(posedge clk_i) begin
    if (rd_take_i) begin
      rsp_q <= '{src_id: rd_src_i, data: rd_data_i};
    end
  end

  assign rsp_valid_o = (state_q == FULL);
  assign rsp_o       = rsp_q;

endmodule

/* design/request_ctrl.sv */
// request decode and acceptance
`timescale 1ns/1ps

module request_ctrl
  import noc_pkg::*;
  import filereg_pkg::*;
(
  // request stream
  input  logic      req_valid_i,
  input  req_t      req_i,
  output logic      req_ready_o,
  // response register can take a new read this cycle
  input  logic      slot_free_i,
  // write strobe into the array
  output logic      wr_en_o,
  output entry_id_t wr_id_o,
  output entry_t    wr_data_o,
  // read select and take strobe
  output entry_id_t rd_id_o,
  output logic      rd_take_o,
  output node_id_t  rd_src_o
);

  logic is_read;
  logic is_write;
  logic xfer;

  // ----------------------------------------------------------
  // command decode
  // ----------------------------------------------------------

  assign is_read  = (req_i.cmd == CMD_READ);
  assign is_write = (req_i.cmd == CMD_WRITE);

  // ----------------------------------------------------------
  // acceptance
  // ----------------------------------------------------------

  // writes always go through
  // a read waits only while a response is stuck in the slot
  assign req_ready_o = !(req_valid_i && is_read && !slot_free_i);
  assign xfer        = req_valid_i && req_ready_o;

  // ----------------------------------------------------------
  // strobes
  // ----------------------------------------------------------

  assign wr_en_o   = xfer && is_write;
  assign rd_take_o = xfer && is_read;

  // entry index is shared by both ports
  assign wr_id_o   = req_i.entry_id;
  assign rd_id_o   = req_i.entry_id;
  assign wr_data_o = req_i.payload;

  // source id sits in the low payload bits of a read
  assign rd_src_o  = req_i.payload[SRC_ID_W-1:0];

endmodule

/* design/reg_array.sv */
// configuration register file
`timescale 1ns/1ps

module reg_array
  import noc_pkg::*;
  import filereg_pkg::*;
#(
  parameter int NumVns = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // default lbdr entry loaded on reset
  input  lbdr_t                    def_entry_i,
  // write port
  input  logic                     wr_en_i,
  input  entry_id_t                wr_id_i,
  input  entry_t                   wr_data_i,
  // asynchronous read port
  input  entry_id_t                rd_id_i,
  output entry_t                   rd_data_o,
  // routing bits of every vn, vn 0 in the low bits
  output lbdr_t [NumVns-1:0]       lbdr_bits_o
);

  // entries that take the lbdr default, bounded by the widest bus
  localparam int DefCount = (NumVns < MAX_VNS) ? NumVns : MAX_VNS;

  entry_t mem_q [DEPTH];

  // ----------------------------------------------------------
  // reset load and write
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        // vn entries start with xy routing, the rest clear
        if (i < DefCount) begin
          mem_q[i] <= entry_t'(def_entry_i);
        end else begin
          mem_q[i] <= '0;
        end
      end
    end else if (wr_en_i) begin
      // one write per cycle, visible from the next cycle
      mem_q[wr_id_i] <= wr_data_i;
    end
  end

  // ----------------------------------------------------------
  // read and lbdr bus
  // ----------------------------------------------------------

  // combinational read, sampled by the response register
  assign rd_data_o = mem_q[rd_id_i];

  // low entries drive the router, upper entry bits ignored
  for (genvar v = 0; v < NumVns; v++) begin : g_lbdr
    assign lbdr_bits_o[v] = mem_q[v][LBDR_W-1:0];
  end

endmodule

/* design/lbdr_default_gen.sv */
// lbdr reset default
`timescale 1ns/1ps

module lbdr_default_gen
  import noc_pkg::*;
#(
  parameter int unsigned NodeId    = 0,
  parameter int unsigned NodesX    = 4,
  parameter int unsigned NodesY    = 4,
  parameter dir_e        XIncrease = EAST,
  parameter dir_e        YIncrease = NORTH
) (
  output lbdr_t def_entry_o
);

  // ----------------------------------------------------------
  // node position
  // ----------------------------------------------------------

  localparam coord_t XCur  = coord_x(node_id_t'(NodeId));
  localparam coord_t YCur  = coord_y(node_id_t'(NodeId));
  localparam int     XLast = int'(NodesX) - 1;
  localparam int     YLast = int'(NodesY) - 1;

  // ----------------------------------------------------------
  // mesh edges seen from this node
  // ----------------------------------------------------------

  // id 0 sits at the west edge when ids grow eastwards
  localparam bit AtWest  = ((XIncrease == EAST) && (int'(XCur) <= 0)) ||
                           ((XIncrease == WEST) && (int'(XCur) >= XLast));
  localparam bit AtEast  = ((XIncrease == EAST) && (int'(XCur) >= XLast)) ||
                           ((XIncrease == WEST) && (int'(XCur) <= 0));

  // id 0 sits at the south edge when ids grow northwards
  localparam bit AtSouth = ((YIncrease == NORTH) && (int'(YCur) <= 0)) ||
                           ((YIncrease == SOUTH) && (int'(YCur) >= YLast));
  localparam bit AtNorth = ((YIncrease == NORTH) && (int'(YCur) >= YLast)) ||
                           ((YIncrease == SOUTH) && (int'(YCur) <= 0));

  // ----------------------------------------------------------
  // entry assembly
  // ----------------------------------------------------------

  always_comb begin
    // routing bits shared by all nodes
    def_entry_o = LBDR_XY_ROUTING;
    // a port is connected unless it faces the mesh boundary
    def_entry_o[LBDR_CN] = !AtNorth;
    def_entry_o[LBDR_CE] = !AtEast;
    def_entry_o[LBDR_CW] = !AtWest;
    def_entry_o[LBDR_CS] = !AtSouth;
  end

endmodule

/* design/filereg_pkg.sv */
// register bank command and stream types
package filereg_pkg;

  // ----------------------------------------------------------
  // register file geometry
  // ----------------------------------------------------------

  // entry width, wide enough to hold one lbdr entry zero-extended
  typedef logic [15:0] entry_t;
  // register index
  typedef logic [2:0]  entry_id_t;

  // number of entries, must cover every value of entry_id_t
  localparam int DEPTH = 8;

  // ----------------------------------------------------------
  // request stream
  // ----------------------------------------------------------

  typedef enum logic {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } cmd_e;

  // write: payload is the new entry value
  // read: low bits of payload carry the requester's source id
  typedef struct packed {
    cmd_e      cmd;
    entry_id_t entry_id;
    entry_t    payload;
  } req_t;

  // ----------------------------------------------------------
  // response stream
  // ----------------------------------------------------------

  // source id travels back so the response can be routed home
  typedef struct packed {
    noc_pkg::node_id_t src_id;
    entry_t            data;
  } rsp_t;

  // width of the source id field inside a read payload
  localparam int SRC_ID_W = $bits(noc_pkg::node_id_t);

  // lbdr entries sit in the low bits of a register
  localparam int LBDR_W = $bits(noc_pkg::lbdr_t);

endpackage

/* design/noc_pkg.sv */
// mesh geometry and lbdr encoding
package noc_pkg;

  // ----------------------------------------------------------
  // node addressing
  // ----------------------------------------------------------

  // node id, also used as the source id of a read requester
  typedef logic [3:0] node_id_t;
  // one mesh coordinate, x in the low half of the id, y in the high half
  typedef logic [1:0] coord_t;

  // directions in which node ids grow along each axis
  typedef enum logic [1:0] {
    NORTH = 2'd0,
    EAST  = 2'd1,
    WEST  = 2'd2,
    SOUTH = 2'd3
  } dir_e;

  // ----------------------------------------------------------
  // lbdr entry layout
  // ----------------------------------------------------------

  typedef logic [11:0] lbdr_t;

  // routing bits, upper byte of the entry
  localparam int LBDR_RNE = 11;
  localparam int LBDR_RNW = 10;
  localparam int LBDR_RSE = 9;
  localparam int LBDR_RSW = 8;
  localparam int LBDR_REN = 7;
  localparam int LBDR_RES = 6;
  localparam int LBDR_RWN = 5;
  localparam int LBDR_RWS = 4;

  // connectivity bits, low nibble
  localparam int LBDR_CN = 3;
  localparam int LBDR_CE = 2;
  localparam int LBDR_CW = 1;
  localparam int LBDR_CS = 0;

  // xy routing only turns out of the x axis into y
  // identical for every node, connectivity left clear
  localparam lbdr_t LBDR_XY_ROUTING = lbdr_t'((1 << LBDR_REN) | (1 << LBDR_RES) |
                                               (1 << LBDR_RWN) | (1 << LBDR_RWS));

  // widest lbdr bus supported by the register bank
  localparam int MAX_VNS = 4;

  // ----------------------------------------------------------
  // coordinate helpers
  // ----------------------------------------------------------

  function automatic coord_t coord_x(node_id_t id);
    return id[1:0];
  endfunction

  function automatic coord_t coord_y(node_id_t id);
    return id[3:2];
  endfunction

endpackage
